//--- hdl/resize_pkg.sv
package resize_pkg;

  // Width of one camera pixel sample.
  localparam int PIX_W = 12;

  // Coordinate width covers frames up to 4096 columns or rows.
  localparam int COORD_W = 12;

  // Number of fractional bits in the fixed-point scaling ratio.
  localparam int RATIO_FRAC = 16;

  // Pixel as it arrives from the camera interface.
  typedef struct packed {
    logic [PIX_W-1:0] data;  // Raw pixel value.
  } pix_in_t;

  // Source pixel tagged with its place in the frame.
  typedef struct packed {
    logic               valid;  // Strobe for an accepted pixel.
    logic [COORD_W-1:0] x;      // Source column.
    logic [COORD_W-1:0] y;      // Source row.
    logic               eol;    // Set on the last column of a line.
    logic               eof;    // Set on the last pixel of the frame.
    logic [PIX_W-1:0]   data;   // Pixel value carried along.
  } src_pos_t;

  // Downscaled pixel with its destination coordinates.
  typedef struct packed {
    logic [PIX_W-1:0]   data;       // Pixel value of the kept source pixel.
    logic [COORD_W-1:0] x;          // Destination column.
    logic [COORD_W-1:0] y;          // Destination row.
    logic               line_end;   // Last pixel of a destination line.
    logic               frame_end;  // Last pixel of the destination frame.
  } pix_out_t;

  // The counter waits for a frame start before it accepts pixels.
  typedef enum logic {
    WAIT_SOF = 1'b0,
    ACTIVE   = 1'b1
  } frame_state_e;

endpackage

//--- hdl/src_position_counter.sv
`timescale 1ns/1ps

module src_position_counter
  import resize_pkg::*;
#(
  parameter int SRC_W = 10,
  parameter int SRC_H = 8
)
(
  input  logic     clk_os,
  input  logic     i_rst_n,
  input  logic     i_pix_valid,    // One strobe per source pixel.
  input  pix_in_t  i_pix,
  input  logic     i_frame_start,  // Comes with the first pixel of a frame.
  output src_pos_t o_pos
);

  localparam logic [COORD_W-1:0] LAST_COL = COORD_W'(SRC_W - 1);
  localparam logic [COORD_W-1:0] LAST_ROW = COORD_W'(SRC_H - 1);

  frame_state_e       state_q;
  logic [COORD_W-1:0] col_q;  // Column that the next pixel will take.
  logic [COORD_W-1:0] row_q;  // Row that the next pixel will take.

  // A frame start forces the current pixel to (0,0) whatever the counts say.
  always_comb
  begin
    o_pos.valid = i_pix_valid && (i_frame_start || (state_q == ACTIVE));
    o_pos.x     = i_frame_start ? '0 : col_q;
    o_pos.y     = i_frame_start ? '0 : row_q;
    o_pos.eol   = (o_pos.x == LAST_COL);
    o_pos.eof   = o_pos.eol && (o_pos.y == LAST_ROW);
    o_pos.data  = i_pix.data;  // Data rides along untouched.
  end

  always_ff @(posedge clk_os)
  begin
    if (!i_rst_n)
    begin
      state_q <= WAIT_SOF;
      col_q   <= '0;
      row_q   <= '0;
    end
    else if (o_pos.valid)  // Pixels outside a frame never get here.
    begin
      if (o_pos.eof)
      begin
        // Frame is complete, so park until the next frame start.
        state_q <= WAIT_SOF;
        col_q   <= '0;
        row_q   <= '0;
      end
      else
      begin
        state_q <= ACTIVE;
        if (o_pos.eol)
        begin
          col_q <= '0;             // Wrap to the start of the next line.
          row_q <= o_pos.y + 1'b1;
        end
        else
        begin
          col_q <= o_pos.x + 1'b1;
          row_q <= o_pos.y;
        end
      end
    end
  end

  // Column never runs past the end of the line.
  a_col_range : assert property (@(posedge clk_os) disable iff (!i_rst_n)
    col_q < COORD_W'(SRC_W));

endmodule

//--- hdl/resize_coord.sv
`timescale 1ns/1ps

module resize_coord
  import resize_pkg::*;
#(
  parameter int SRC_W = 10,
  parameter int SRC_H = 8,
  parameter int DST_W = 4,
  parameter int DST_H = 3
)
(
  input  logic               clk_os,
  input  logic               i_rst_n,
  input  src_pos_t           i_pos,
  input  logic               i_frame_start,
  output logic               o_reach,   // Current pixel is a kept one.
  output logic [COORD_W-1:0] o_dst_x,   // Destination column of the pixel.
  output logic [COORD_W-1:0] o_dst_y    // Destination row of the pixel.
);

  // Ratios are rounded up by one LSB so the last step lands past the frame.
  localparam int unsigned X_RATIO = ((SRC_W << RATIO_FRAC) / DST_W) + 1;
  localparam int unsigned Y_RATIO = ((SRC_H << RATIO_FRAC) / DST_H) + 1;

  localparam logic [COORD_W-1:0] LAST_KX  = COORD_W'(DST_W - 1);
  localparam logic [COORD_W-1:0] LAST_KY  = COORD_W'(DST_H - 1);
  localparam logic [COORD_W-1:0] LAST_COL = COORD_W'(SRC_W - 1);

  logic [COORD_W-1:0] kx_q;       // Index of the next kept column.
  logic [COORD_W-1:0] ky_q;       // Index of the next kept row.
  logic [COORD_W-1:0] tgt_x_q;    // Source column of the next kept column.
  logic [COORD_W-1:0] tgt_y_q;    // Source row of the next kept row.
  logic [COORD_W-1:0] kx_cur;
  logic [COORD_W-1:0] ky_cur;
  logic [COORD_W-1:0] tgt_x_cur;
  logic [COORD_W-1:0] tgt_y_cur;
  logic [COORD_W-1:0] kx_inc;
  logic [COORD_W-1:0] ky_inc;
  logic [47:0]        x_prod;     // Wide enough for any index times ratio.
  logic [47:0]        y_prod;
  logic               x_hit;
  logic               y_hit;

  always_comb
  begin
    // A frame start sees the tracker as freshly cleared.
    kx_cur    = i_frame_start ? '0 : kx_q;
    ky_cur    = i_frame_start ? '0 : ky_q;
    tgt_x_cur = i_frame_start ? '0 : tgt_x_q;
    tgt_y_cur = i_frame_start ? '0 : tgt_y_q;
    x_hit     = i_pos.valid && (i_pos.x == tgt_x_cur);
    y_hit     = i_pos.valid && (i_pos.y == tgt_y_cur);
    kx_inc    = kx_cur + 1'b1;
    ky_inc    = ky_cur + 1'b1;
    // Next target is floor((k+1) * ratio) in whole source pixels.
    x_prod    = 48'(kx_inc) * 48'(X_RATIO);
    y_prod    = 48'(ky_inc) * 48'(Y_RATIO);
  end

  assign o_reach = x_hit && y_hit;
  assign o_dst_x = kx_cur;
  assign o_dst_y = ky_cur;

  always_ff @(posedge clk_os)
  begin
    if (!i_rst_n || (i_pos.valid && i_pos.eof))
    begin
      kx_q    <= '0;
      ky_q    <= '0;
      tgt_x_q <= '0;
      tgt_y_q <= '0;
    end
    else if (i_pos.valid)
    begin
      if (i_pos.eol)
      begin
        kx_q    <= '0;  // Every line starts again at column 0.
        tgt_x_q <= '0;
        // Only a kept row moves the row target on.
        if (y_hit && (ky_cur != LAST_KY))
        begin
          ky_q    <= ky_inc;
          tgt_y_q <= y_prod[RATIO_FRAC +: COORD_W];
        end
        else
        begin
          ky_q    <= ky_cur;
          tgt_y_q <= tgt_y_cur;
        end
      end
      else
      begin
        ky_q    <= ky_cur;
        tgt_y_q <= tgt_y_cur;
        // The last kept column holds its target until the line wraps.
        if (x_hit && (kx_cur != LAST_KX))
        begin
          kx_q    <= kx_inc;
          tgt_x_q <= x_prod[RATIO_FRAC +: COORD_W];
        end
        else
        begin
          kx_q    <= kx_cur;
          tgt_x_q <= tgt_x_cur;
        end
      end
    end
  end

  a_no_upscale : assert property (@(posedge clk_os)
    (DST_W <= SRC_W) && (DST_H <= SRC_H));  // Shrinking keeps targets reachable.

  a_tgt_x_range : assert property (@(posedge clk_os) disable iff (!i_rst_n)
    tgt_x_q <= LAST_COL);

endmodule

//--- hdl/pixel_select.sv
`timescale 1ns/1ps

module pixel_select
  import resize_pkg::*;
#(
  parameter int DST_W = 4,
  parameter int DST_H = 3
)
(
  input  logic               clk_os,
  input  logic               i_rst_n,
  input  src_pos_t           i_pos,
  input  logic               i_reach,    // Pixel sits on a kept column and row.
  input  logic [COORD_W-1:0] i_dst_x,
  input  logic [COORD_W-1:0] i_dst_y,
  output logic               o_out_valid,
  output pix_out_t           o_out
);

  localparam logic [COORD_W-1:0] LAST_KX = COORD_W'(DST_W - 1);
  localparam logic [COORD_W-1:0] LAST_KY = COORD_W'(DST_H - 1);

  logic     capture;     // Current pixel goes to the output.
  logic     line_end;
  logic     frame_end;
  logic     valid_q;
  pix_out_t out_q;

  always_comb
  begin
    capture   = i_pos.valid && i_reach;
    // End marks come from the destination indices, not the source position.
    line_end  = (i_dst_x == LAST_KX);
    frame_end = line_end && (i_dst_y == LAST_KY);
  end

  // Output strobe, one cycle per captured pixel.
  always_ff @(posedge clk_os)
  begin
    if (!i_rst_n)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= capture;  // High for exactly one cycle per kept pixel.
    end
  end

  // Output payload only moves when a kept pixel is captured.
  always_ff @(posedge clk_os)
  begin
    if (capture)
    begin
      out_q.data      <= i_pos.data;
      out_q.x         <= i_dst_x;
      out_q.y         <= i_dst_y;
      out_q.line_end  <= line_end;
      out_q.frame_end <= frame_end;
    end
  end

  assign o_out_valid = valid_q;
  assign o_out       = out_q;

  // A reached pixel always lands inside the destination frame, so the end marks can fire.
  a_dst_range : assert property (@(posedge clk_os) disable iff (!i_rst_n)
    i_reach |-> ((i_dst_x <= LAST_KX) && (i_dst_y <= LAST_KY)));

endmodule

//--- hdl/resize_top.sv
`timescale 1ns/1ps

module resize_top
  import resize_pkg::*;
#(
  parameter int SRC_W = 10,  // Source frame width in pixels.
  parameter int SRC_H = 8,   // Source frame height in lines.
  parameter int DST_W = 4,   // Destination width, no larger than SRC_W.
  parameter int DST_H = 3    // Destination height, no larger than SRC_H.
)
(
  input  logic     clk_os,
  input  logic     i_rst_n,
  input  logic     i_pix_valid,
  input  pix_in_t  i_pix,
  input  logic     i_frame_start,
  output logic     o_out_valid,
  output pix_out_t o_out
);

  src_pos_t           pos;     // Source pixel with its frame position.
  logic               reach;   // Pixel is on a kept column and row.
  logic [COORD_W-1:0] dst_x;
  logic [COORD_W-1:0] dst_y;

  // Source column and row of each pixel.
  src_position_counter #(.SRC_W(SRC_W), .SRC_H(SRC_H)) u_counter (
    .clk_os        (clk_os),
    .i_rst_n       (i_rst_n),
    .i_pix_valid   (i_pix_valid),
    .i_pix         (i_pix),
    .i_frame_start (i_frame_start),
    .o_pos         (pos)
  );

  // Decides which source pixels survive the downscale.
  resize_coord #(.SRC_W(SRC_W), .SRC_H(SRC_H), .DST_W(DST_W), .DST_H(DST_H)) u_coord (
    .clk_os        (clk_os),
    .i_rst_n       (i_rst_n),
    .i_pos         (pos),
    .i_frame_start (i_frame_start),
    .o_reach       (reach),
    .o_dst_x       (dst_x),
    .o_dst_y       (dst_y)
  );

  pixel_select #(.DST_W(DST_W), .DST_H(DST_H)) u_select (
    .clk_os      (clk_os),
    .i_rst_n     (i_rst_n),
    .i_pos       (pos),
    .i_reach     (reach),
    .i_dst_x     (dst_x),
    .i_dst_y     (dst_y),
    .o_out_valid (o_out_valid),  // One cycle after the kept input strobe.
    .o_out       (o_out)
  );

endmodule

//--- verif/clk_gen.sv
`timescale 1ns/1ps

// Free-running clock for the testbench.
module clk_gen
#(
  parameter real PERIOD_NS = 8.0  // Full clock period in ns.
)
(
  output logic o_clk
);

  initial
  begin
    o_clk = 1'b0;  // Start low so the first rising edge is half a period in.
    forever
    begin
      #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end
  end

endmodule

//--- verif/tb_resize.sv
`timescale 1ns/1ps

module tb_resize
  import resize_pkg::*;
();

  localparam int SRC_W = 10;  // Same frame sizes as the DUT defaults.
  localparam int SRC_H = 8;
  localparam int DST_W = 4;
  localparam int DST_H = 3;
  // Pixels over all tests: two frames, 5 stray, 25 partial, one frame, three frames.
  localparam int TOTAL_PIX = 80 + 80 + 5 + 25 + 80 + 3 * 80;
  localparam int WATCHDOG_CYC = TOTAL_PIX * 4 + 600;  // Gaps cost at most 3 idle cycles.

  logic     clk_os;
  logic     i_rst_n;
  logic     i_pix_valid;
  pix_in_t  i_pix;
  logic     i_frame_start;
  logic     o_out_valid;
  pix_out_t o_out;

  int          col_dst[SRC_W];  // Destination column of each source column, or -1.
  int          row_dst[SRC_H];  // Destination row of each source row, or -1.
  pix_out_t    exp_q[$];        // Outputs still owed by the DUT.
  int unsigned exp_cyc_q[$];    // Cycle count at which each one is due.
  int unsigned cyc = 0;
  int          errors = 0;
  int          out_count = 0;
  int          frame_end_count = 0;
  string       test_name = "none";

  clk_gen #(.PERIOD_NS(8.0)) u_clk (.o_clk(clk_os));

  resize_top dut (
    .clk_os        (clk_os),
    .i_rst_n       (i_rst_n),
    .i_pix_valid   (i_pix_valid),
    .i_pix         (i_pix),
    .i_frame_start (i_frame_start),
    .o_out_valid   (o_out_valid),
    .o_out         (o_out)
  );

  always @(posedge clk_os)
  begin
    cyc <= cyc + 1;  // Cycle stamp for the latency check.
  end

  task automatic report_mismatch(input string field, input int expected, input int actual);
    errors++;
    $display("mismatch %s %s expected %0h actual %0h", test_name, field, expected, actual);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("error in %s: %s", test_name, what);
  endtask

  // Kept column k sits at floor(k * ratio), the ratio being rounded up by one LSB.
  task automatic build_model();
    longint x_ratio;
    longint y_ratio;
    int     k;
    int     pos;
    x_ratio = ((longint'(SRC_W) << RATIO_FRAC) / DST_W) + 1;
    y_ratio = ((longint'(SRC_H) << RATIO_FRAC) / DST_H) + 1;
    foreach (col_dst[i]) col_dst[i] = -1;
    foreach (row_dst[i]) row_dst[i] = -1;
    for (k = 0; k < DST_W; k++)
    begin
      pos = int'((longint'(k) * x_ratio) >>> RATIO_FRAC);
      if (pos < SRC_W) col_dst[pos] = k;
      else report_failure("kept column falls outside the source line");
    end
    for (k = 0; k < DST_H; k++)
    begin
      pos = int'((longint'(k) * y_ratio) >>> RATIO_FRAC);
      if (pos < SRC_H) row_dst[pos] = k;
      else report_failure("kept row falls outside the source frame");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_os);
    i_rst_n       <= 1'b0;
    i_pix_valid   <= 1'b0;
    i_frame_start <= 1'b0;
    repeat (2) @(posedge clk_os);  // Two edges see reset low.
    i_rst_n <= 1'b1;
  endtask

  task automatic drive_pixel(input logic sof, input logic [PIX_W-1:0] data);
    @(posedge clk_os);
    i_pix_valid   <= 1'b1;
    i_frame_start <= sof;
    i_pix.data    <= data;
  endtask

  task automatic drive_idle(input int n);
    repeat (n)
    begin
      @(posedge clk_os);
      i_pix_valid   <= 1'b0;
      i_frame_start <= 1'b0;
    end
  endtask

  // Called in the same step as drive_pixel, so cyc still holds the old count.
  task automatic expect_pixel(input int x, input int y, input logic [PIX_W-1:0] data);
    pix_out_t exp_pix;
    if ((col_dst[x] >= 0) && (row_dst[y] >= 0))
    begin
      exp_pix.data      = data;
      exp_pix.x         = COORD_W'(col_dst[x]);
      exp_pix.y         = COORD_W'(row_dst[y]);
      exp_pix.line_end  = (col_dst[x] == DST_W - 1);
      exp_pix.frame_end = exp_pix.line_end && (row_dst[y] == DST_H - 1);
      exp_q.push_back(exp_pix);
      exp_cyc_q.push_back(cyc + 2);  // Captured on the next edge, seen one edge later.
    end
  endtask

  // Sends the first npix pixels of a frame in raster order.
  task automatic send_frame(input int npix, input int gap_max, input bit rand_data);
    int               x;
    int               y;
    logic [PIX_W-1:0] data;
    for (int p = 0; p < npix; p++)
    begin
      x    = p % SRC_W;
      y    = p / SRC_W;
      data = rand_data ? PIX_W'($urandom()) : PIX_W'((y << 6) | x);
      drive_pixel(p == 0, data);
      expect_pixel(x, y, data);
      if (gap_max > 0) drive_idle($urandom_range(0, gap_max));
    end
  endtask

  task automatic wait_drain();
    int waited;
    drive_idle(1);
    waited = 0;
    while ((exp_q.size() != 0) && (waited < 16))
    begin
      @(negedge clk_os);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      report_failure("expected outputs never appeared");
      exp_q.delete();
      exp_cyc_q.delete();
    end
    drive_idle(3);  // Quiet cycles let the monitor catch stray strobes.
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    if (expected != actual) report_mismatch(what, expected, actual);
  endtask

  task automatic test_reset();
    test_name = "reset";
    apply_reset();
    repeat (10)
    begin
      @(negedge clk_os);
      if (o_out_valid !== 1'b0) report_failure("output strobe raised with no input after reset");
    end
  endtask

  task automatic test_full_frame();
    int outs0;
    int ends0;
    test_name = "full_frame";
    outs0 = out_count;
    ends0 = frame_end_count;
    send_frame(SRC_W * SRC_H, 0, 1'b0);
    wait_drain();
    check_count("output count", DST_W * DST_H, out_count - outs0);
    check_count("frame_end count", 1, frame_end_count - ends0);
  endtask

  task automatic test_idle_gaps();
    int outs0;
    int ends0;
    test_name = "idle_gaps";
    outs0 = out_count;
    ends0 = frame_end_count;
    send_frame(SRC_W * SRC_H, 3, 1'b0);  // Same data as the full frame test.
    wait_drain();
    check_count("output count", DST_W * DST_H, out_count - outs0);
    check_count("frame_end count", 1, frame_end_count - ends0);
  endtask

  task automatic test_resync();
    int outs0;
    int ends0;
    test_name = "resync";
    apply_reset();
    outs0 = out_count;
    ends0 = frame_end_count;
    repeat (5) drive_pixel(1'b0, PIX_W'($urandom()));  // No frame start yet, so all dropped.
    wait_drain();
    check_count("dropped pixel outputs", 0, out_count - outs0);
    // Rows 0 and 1 plus five pixels of row 2 give 4 + 2 kept pixels.
    send_frame(25, 0, 1'b1);
    send_frame(SRC_W * SRC_H, 0, 1'b1);  // Frame start lands mid frame.
    wait_drain();
    check_count("output count", 6 + DST_W * DST_H, out_count - outs0);
    check_count("frame_end count", 1, frame_end_count - ends0);
  endtask

  task automatic test_multi_frame();
    int outs0;
    int ends0;
    test_name = "multi_frame";
    outs0 = out_count;
    ends0 = frame_end_count;
    repeat (3) send_frame(SRC_W * SRC_H, 0, 1'b1);  // Frames follow with no gap.
    wait_drain();
    check_count("output count", 3 * DST_W * DST_H, out_count - outs0);
    check_count("frame_end count", 3, frame_end_count - ends0);
  endtask

  // Outputs are compared at the falling edge where they are stable.
  always @(negedge clk_os)
  begin
    pix_out_t    exp_pix;
    int unsigned exp_cyc;
    if (o_out_valid === 1'b1)
    begin
      out_count++;
      if (o_out.frame_end === 1'b1) frame_end_count++;
      if (exp_q.size() == 0)
      begin
        report_failure("output strobe with no kept input behind it");
      end
      else
      begin
        exp_pix = exp_q.pop_front();
        exp_cyc = exp_cyc_q.pop_front();
        if (o_out.data !== exp_pix.data)
          report_mismatch("data", int'(exp_pix.data), int'(o_out.data));
        if (o_out.x !== exp_pix.x) report_mismatch("dst x", int'(exp_pix.x), int'(o_out.x));
        if (o_out.y !== exp_pix.y) report_mismatch("dst y", int'(exp_pix.y), int'(o_out.y));
        if (o_out.line_end !== exp_pix.line_end)
          report_mismatch("line_end", int'(exp_pix.line_end), int'(o_out.line_end));
        if (o_out.frame_end !== exp_pix.frame_end)
          report_mismatch("frame_end", int'(exp_pix.frame_end), int'(o_out.frame_end));
        if (cyc != exp_cyc) report_mismatch("output cycle", int'(exp_cyc), int'(cyc));
      end
    end
  end

  initial
  begin
    void'($urandom(32'hfeac8788));
    i_rst_n       = 1'b0;
    i_pix_valid   = 1'b0;
    i_pix         = '0;
    i_frame_start = 1'b0;
    build_model();
    test_reset();
    test_full_frame();
    test_idle_gaps();
    test_resync();
    test_multi_frame();
    $display("outputs %0d frame ends %0d errors %0d", out_count, frame_end_count, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge clk_os);
    $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYC, test_name);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- sim.f
hdl/resize_pkg.sv
hdl/src_position_counter.sv
hdl/resize_coord.sv
hdl/pixel_select.sv
hdl/resize_top.sv
verif/clk_gen.sv
verif/tb_resize.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_resize
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

# Every source named in the file list, so a change there triggers a rebuild.
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The log decides the result, whatever the binary returns.
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
